// File: build.f
dcache_pkg.sv
dcache_sram.sv
dcache_tags.sv
dcache_ctrl.sv
dcache_top.sv
tb_axi_mem.sv
tb_dcache.sv

// File: dcache_ctrl.sv
`timescale 1ns/1ps
// dcache controller
// accepts one cpu request at a time, checks the tag store and on a miss
// writes back a dirty victim and refills the line before serving the request
module dcache_ctrl #(
  parameter int  index_width = 6,
  localparam int tag_width   = dcache_pkg::addr_width - index_width - dcache_pkg::offset_width
) (
  input  logic                              clk,
  input  logic                              rst,
  // cpu side
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [dcache_pkg::addr_width-1:0] ar_addr_i,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [dcache_pkg::data_width-1:0] r_data_o,
  output logic [1:0]                        r_resp_o,
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [dcache_pkg::addr_width-1:0] aw_addr_i,
  input  logic                              w_valid_i,
  output logic                              w_ready_o,
  input  logic [dcache_pkg::strb_width-1:0] w_strb_i,
  input  logic [dcache_pkg::data_width-1:0] w_data_i,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output logic [1:0]                        b_resp_o,
  // memory side
  output logic                              mem_ar_valid_o,
  input  logic                              mem_ar_ready_i,
  output logic [dcache_pkg::addr_width-1:0] mem_ar_addr_o,
  input  logic                              mem_r_valid_i,
  output logic                              mem_r_ready_o,
  input  logic [dcache_pkg::data_width-1:0] mem_r_data_i,
  input  logic [1:0]                        mem_r_resp_i,
  output logic                              mem_aw_valid_o,
  input  logic                              mem_aw_ready_i,
  output logic [dcache_pkg::addr_width-1:0] mem_aw_addr_o,
  output logic                              mem_w_valid_o,
  input  logic                              mem_w_ready_i,
  output logic [dcache_pkg::strb_width-1:0] mem_w_strb_o,
  output logic [dcache_pkg::data_width-1:0] mem_w_data_o,
  input  logic                              mem_b_valid_i,
  output logic                              mem_b_ready_o,
  input  logic [1:0]                        mem_b_resp_i,
  // tag store
  output logic [index_width-1:0]            lookup_index_o,
  output logic [tag_width-1:0]              lookup_tag_o,
  input  logic                              hit_i,
  input  logic                              hit_way_i,
  input  logic                              victim_way_i,
  input  logic                              victim_dirty_i,
  input  logic [tag_width-1:0]              victim_tag_i,
  output logic                              tag_we_o,
  output logic                              valid_set_o,
  output logic                              valid_clr_o,
  output logic                              dirty_set_o,
  output logic                              dirty_clr_o,
  output logic                              way_sel_o,
  // data arrays
  output logic [dcache_pkg::way_count-1:0]  ram_en_o,
  output logic                              ram_we_o,
  output logic [dcache_pkg::strb_width-1:0] ram_bmask_o,
  output logic [index_width-1:0]            ram_index_o,
  output logic [dcache_pkg::data_width-1:0] ram_wdata_o,
  input  logic [dcache_pkg::data_width-1:0] ram_rdata_i [dcache_pkg::way_count]
);
  import dcache_pkg::*;

  ctrl_state_t           state_q;
  logic [addr_width-1:0] addr_q;
  logic [addr_width-1:0] wb_addr_q;
  logic [addr_width-1:0] req_addr;
  logic [addr_width-1:0] lookup_addr;
  logic                  is_wr_q;
  logic                  way_q;
  logic                  hit_go_q;   // first hit cycle done
  logic [1:0]            resp_q;
  logic                  ar_hs;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  fill_hs;
  logic                  rd_issue;
  logic                  rd_capture;

  assign ar_ready_o = (state_q == idle);
  assign aw_ready_o = (state_q == idle) && !ar_valid_i;   // read wins
  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign aw_hs      = aw_valid_i && aw_ready_o;
  assign w_hs       = w_valid_i && w_ready_o;
  assign fill_hs    = (state_q == fill_data) && mem_r_valid_i;
  assign req_addr   = ar_valid_i ? ar_addr_i : aw_addr_i;

  // incoming address while idle, latched one for the rest of the request
  assign lookup_addr    = (state_q == idle) ? req_addr : addr_q;
  assign lookup_index_o = lookup_addr[offset_width +: index_width];
  assign lookup_tag_o   = lookup_addr[addr_width-1 -: tag_width];

  // read hit: sram read in the first cycle, output registered in the second
  assign rd_issue   = (state_q == hit) && !hit_go_q && !is_wr_q;
  assign rd_capture = (state_q == hit) && hit_go_q && !is_wr_q && !r_valid_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= idle;
      is_wr_q   <= 1'b0;
      way_q     <= 1'b0;
      hit_go_q  <= 1'b0;
      resp_q    <= resp_okay;
      r_valid_o <= 1'b0;
      w_ready_o <= 1'b0;
      b_valid_o <= 1'b0;
    end else begin
      case (state_q)
        idle: begin
          hit_go_q <= 1'b0;
          if (ar_hs || aw_hs) begin
            is_wr_q <= aw_hs;
            resp_q  <= resp_okay;
            if (hit_i) begin
              way_q   <= hit_way_i;
              state_q <= hit;
            end else begin
              way_q   <= victim_way_i;
              state_q <= victim_dirty_i ? wb_addr : fill_addr;
            end
          end
        end
        hit: begin
          hit_go_q <= 1'b1;
          if (!hit_go_q && is_wr_q) begin
            w_ready_o <= 1'b1;   // line is present now
          end
          if (rd_capture) begin
            r_valid_o <= 1'b1;
          end
          if (w_hs) begin
            w_ready_o <= 1'b0;
            b_valid_o <= 1'b1;
          end
          if (r_valid_o && r_ready_i) begin
            r_valid_o <= 1'b0;
            state_q   <= idle;
          end
          if (b_valid_o && b_ready_i) begin
            b_valid_o <= 1'b0;
            state_q   <= idle;
          end
        end
        wb_addr: begin
          if (mem_aw_ready_i) begin
            state_q <= wb_data;
          end
        end
        wb_data: begin
          if (mem_w_ready_i) begin
            state_q <= wb_resp;
          end
        end
        wb_resp: begin
          if (mem_b_valid_i) begin
            resp_q  <= resp_q | mem_b_resp_i;
            state_q <= fill_addr;
          end
        end
        fill_addr: begin
          if (mem_ar_ready_i) begin
            state_q <= fill_data;
          end
        end
        fill_data: begin
          if (mem_r_valid_i) begin
            resp_q  <= resp_q | mem_r_resp_i;
            state_q <= hit;   // serve the request from the refilled line
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  // request address and victim address, both word aligned
  always_ff @(posedge clk) begin
    if (ar_hs || aw_hs) begin
      addr_q    <= {req_addr[addr_width-1:offset_width], {offset_width{1'b0}}};
      wb_addr_q <= {victim_tag_i, lookup_index_o, {offset_width{1'b0}}};
    end
    if (rd_capture) begin
      r_data_o <= ram_rdata_i[way_q];
    end
  end

  assign r_resp_o = resp_q;   // sticky over the miss sequence
  assign b_resp_o = resp_q;

  // tag store updates
  assign way_sel_o   = way_q;
  assign valid_clr_o = (state_q == fill_addr);
  assign tag_we_o    = fill_hs;
  assign valid_set_o = fill_hs;
  assign dirty_clr_o = fill_hs;   // refilled line is clean
  assign dirty_set_o = w_hs;

  // data arrays
  assign ram_we_o    = fill_hs || w_hs;
  assign ram_bmask_o = fill_hs ? '1 : w_strb_i;
  assign ram_wdata_o = fill_hs ? mem_r_data_i : w_data_i;
  assign ram_index_o = addr_q[offset_width +: index_width];

  always_comb begin
    ram_en_o        = '0;
    // victim word is read while the write-back address is out
    ram_en_o[way_q] = ram_we_o || rd_issue || (state_q == wb_addr);
  end

  // memory side
  assign mem_aw_valid_o = (state_q == wb_addr);
  assign mem_aw_addr_o  = wb_addr_q;
  assign mem_w_valid_o  = (state_q == wb_data);
  assign mem_w_strb_o   = '1;
  assign mem_w_data_o   = ram_rdata_i[way_q];
  assign mem_b_ready_o  = (state_q == wb_resp);
  assign mem_ar_valid_o = (state_q == fill_addr);
  assign mem_ar_addr_o  = addr_q;
  assign mem_r_ready_o  = (state_q == fill_data);

endmodule

// File: dcache_pkg.sv
// dcache shared definitions
// widths of the cpu and memory buses, response code and controller states
package dcache_pkg;

  localparam int addr_width   = 32;
  localparam int data_width   = 64;
  localparam int strb_width   = data_width / 8;
  localparam int offset_width = 3;   // byte within the 64-bit word

  // hit encode in the tag store only handles two ways
  localparam int way_count = 2;

  localparam logic [1:0] resp_okay = 2'b00;

  typedef enum logic [2:0] {
    idle,
    hit,
    wb_addr,     // victim write-back
    wb_data,
    wb_resp,
    fill_addr,   // refill from memory
    fill_data
  } ctrl_state_t;

endpackage

// File: dcache_sram.sv
`timescale 1ns/1ps
// dcache data array, one instance per way
// single port, byte write enables, read data registered one cycle after enable
module dcache_sram #(
  parameter int index_width = 6
) (
  input  logic                                clk,
  input  logic                                en_i,
  input  logic                                we_i,
  input  logic [dcache_pkg::strb_width-1:0]   bmask_i,
  input  logic [index_width-1:0]              index_i,
  input  logic [dcache_pkg::data_width-1:0]   wdata_i,
  output logic [dcache_pkg::data_width-1:0]   rdata_o
);
  import dcache_pkg::*;

  localparam int depth = 1 << index_width;

  logic [data_width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int b = 0; b < strb_width; b++) begin
          if (bmask_i[b]) begin
            mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[index_i];   // holds until the next read
      end
    end
  end

endmodule

// File: dcache_tags.sv
`timescale 1ns/1ps
// dcache tag store
// per-way tag, valid and dirty arrays with combinational hit compare,
// hit way encode and a free-running victim counter for replacement
module dcache_tags #(
  parameter int  index_width = 6,
  localparam int tag_width   = dcache_pkg::addr_width - index_width - dcache_pkg::offset_width
) (
  input  logic                   clk,
  input  logic                   rst,
  // lookup
  input  logic [index_width-1:0] index_i,
  input  logic [tag_width-1:0]   tag_i,
  output logic                   hit_o,
  output logic                   hit_way_o,
  output logic                   victim_way_o,
  output logic                   victim_dirty_o,
  output logic [tag_width-1:0]   victim_tag_o,
  // update, all at index_i in way_i
  input  logic                   tag_we_i,
  input  logic                   valid_set_i,
  input  logic                   valid_clr_i,
  input  logic                   dirty_set_i,
  input  logic                   dirty_clr_i,
  input  logic                   way_i
);
  import dcache_pkg::*;

  localparam int depth = 1 << index_width;

  logic [tag_width-1:0] tag_mem [way_count][depth];
  logic [depth-1:0]     valid_q [way_count];
  logic [depth-1:0]     dirty_q [way_count];
  logic [way_count-1:0] hit_vec;
  logic                 victim_q;

  always_ff @(posedge clk) begin
    if (tag_we_i) begin
      tag_mem[way_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < way_count; w++) begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      victim_q <= 1'b0;
    end else begin
      victim_q <= ~victim_q;   // advances every clock
      if (valid_set_i) begin
        valid_q[way_i][index_i] <= 1'b1;
      end else if (valid_clr_i) begin
        valid_q[way_i][index_i] <= 1'b0;
      end
      if (dirty_set_i) begin
        dirty_q[way_i][index_i] <= 1'b1;
      end else if (dirty_clr_i) begin
        dirty_q[way_i][index_i] <= 1'b0;
      end
    end
  end

  for (genvar w = 0; w < way_count; w++) begin : g_cmp
    assign hit_vec[w] = valid_q[w][index_i] && (tag_mem[w][index_i] == tag_i);
  end

  assign hit_o     = |hit_vec;
  assign hit_way_o = hit_vec[1];   // two ways only

  // victim info follows the counter, the controller latches it on acceptance
  assign victim_way_o   = victim_q;
  assign victim_dirty_o = valid_q[victim_q][index_i] && dirty_q[victim_q][index_i];
  assign victim_tag_o   = tag_mem[victim_q][index_i];

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps
// dcache top
// 2-way set-associative write-back data cache, one 64-bit word per line
// controller, tag store and one data array per way
module dcache_top #(
  parameter int index_width = 6
) (
  input  logic                              clk,
  input  logic                              rst,
  // cpu side
  input  logic                              ar_valid_i,
  output logic                              ar_ready_o,
  input  logic [dcache_pkg::addr_width-1:0] ar_addr_i,
  output logic                              r_valid_o,
  input  logic                              r_ready_i,
  output logic [dcache_pkg::data_width-1:0] r_data_o,
  output logic [1:0]                        r_resp_o,
  input  logic                              aw_valid_i,
  output logic                              aw_ready_o,
  input  logic [dcache_pkg::addr_width-1:0] aw_addr_i,
  input  logic                              w_valid_i,
  output logic                              w_ready_o,
  input  logic [dcache_pkg::strb_width-1:0] w_strb_i,
  input  logic [dcache_pkg::data_width-1:0] w_data_i,
  output logic                              b_valid_o,
  input  logic                              b_ready_i,
  output logic [1:0]                        b_resp_o,
  // memory side
  output logic                              mem_ar_valid_o,
  input  logic                              mem_ar_ready_i,
  output logic [dcache_pkg::addr_width-1:0] mem_ar_addr_o,
  input  logic                              mem_r_valid_i,
  output logic                              mem_r_ready_o,
  input  logic [dcache_pkg::data_width-1:0] mem_r_data_i,
  input  logic [1:0]                        mem_r_resp_i,
  output logic                              mem_aw_valid_o,
  input  logic                              mem_aw_ready_i,
  output logic [dcache_pkg::addr_width-1:0] mem_aw_addr_o,
  output logic                              mem_w_valid_o,
  input  logic                              mem_w_ready_i,
  output logic [dcache_pkg::strb_width-1:0] mem_w_strb_o,
  output logic [dcache_pkg::data_width-1:0] mem_w_data_o,
  input  logic                              mem_b_valid_i,
  output logic                              mem_b_ready_o,
  input  logic [1:0]                        mem_b_resp_i
);
  import dcache_pkg::*;

  localparam int tag_width = addr_width - index_width - offset_width;

  // controller to tag store
  logic [index_width-1:0] lookup_index;
  logic [tag_width-1:0]   lookup_tag;
  logic                   hit;
  logic                   hit_way;
  logic                   victim_way;
  logic                   victim_dirty;
  logic [tag_width-1:0]   victim_tag;
  logic                   tag_we;
  logic                   valid_set;
  logic                   valid_clr;
  logic                   dirty_set;
  logic                   dirty_clr;
  logic                   way_sel;

  // controller to data arrays
  logic [way_count-1:0]   ram_en;
  logic                   ram_we;
  logic [strb_width-1:0]  ram_bmask;
  logic [index_width-1:0] ram_index;
  logic [data_width-1:0]  ram_wdata;
  logic [data_width-1:0]  ram_rdata [way_count];

  // cpu and memory ports connect by name
  dcache_ctrl #(.index_width(index_width)) ctrl_i (
    .*,
    .lookup_index_o (lookup_index),
    .lookup_tag_o   (lookup_tag),
    .hit_i          (hit),
    .hit_way_i      (hit_way),
    .victim_way_i   (victim_way),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .tag_we_o       (tag_we),
    .valid_set_o    (valid_set),
    .valid_clr_o    (valid_clr),
    .dirty_set_o    (dirty_set),
    .dirty_clr_o    (dirty_clr),
    .way_sel_o      (way_sel),
    .ram_en_o       (ram_en),
    .ram_we_o       (ram_we),
    .ram_bmask_o    (ram_bmask),
    .ram_index_o    (ram_index),
    .ram_wdata_o    (ram_wdata),
    .ram_rdata_i    (ram_rdata)
  );

  dcache_tags #(.index_width(index_width)) tags_i (
    .clk            (clk),
    .rst            (rst),
    .index_i        (lookup_index),
    .tag_i          (lookup_tag),
    .hit_o          (hit),
    .hit_way_o      (hit_way),
    .victim_way_o   (victim_way),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .tag_we_i       (tag_we),
    .valid_set_i    (valid_set),
    .valid_clr_i    (valid_clr),
    .dirty_set_i    (dirty_set),
    .dirty_clr_i    (dirty_clr),
    .way_i          (way_sel)
  );

  for (genvar w = 0; w < way_count; w++) begin : g_way
    dcache_sram #(.index_width(index_width)) sram_i (
      .clk     (clk),
      .en_i    (ram_en[w]),
      .we_i    (ram_we),
      .bmask_i (ram_bmask),
      .index_i (ram_index),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata[w])
    );
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_dcache \
  -o sim_dcache > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// File: tb_axi_mem.sv
`timescale 1ns/1ps
// memory-side slave model for the dcache testbench
// random ready and valid delays, one beat per transaction, backing store
// starts as {word address, ~word address}
module tb_axi_mem (
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_ar_valid_i,
  output logic        mem_ar_ready_o,
  input  logic [31:0] mem_ar_addr_i,
  output logic        mem_r_valid_o,
  input  logic        mem_r_ready_i,
  output logic [63:0] mem_r_data_o,
  output logic [1:0]  mem_r_resp_o,
  input  logic        mem_aw_valid_i,
  output logic        mem_aw_ready_o,
  input  logic [31:0] mem_aw_addr_i,
  input  logic        mem_w_valid_i,
  output logic        mem_w_ready_o,
  input  logic [7:0]  mem_w_strb_i,
  input  logic [63:0] mem_w_data_i,
  output logic        mem_b_valid_o,
  input  logic        mem_b_ready_i,
  output logic [1:0]  mem_b_resp_o
);

  logic [63:0] store [logic [28:0]];
  logic [31:0] rng;
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [2:0]  rd_wait;
  logic [2:0]  b_wait;
  logic        rd_pending;
  logic        aw_done;
  logic        b_pending;

  assign mem_r_resp_o = 2'b00;
  assign mem_b_resp_o = 2'b00;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // current word at a byte address, also used by the testbench
  function automatic logic [63:0] peek(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {3'b000, addr[31:3]};
    if (store.exists(addr[31:3])) return store[addr[31:3]];
    return {wa, ~wa};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      rng            <= 32'haf13_72af;
      mem_ar_ready_o <= 1'b0;
      mem_r_valid_o  <= 1'b0;
      mem_aw_ready_o <= 1'b0;
      mem_w_ready_o  <= 1'b0;
      mem_b_valid_o  <= 1'b0;
      rd_pending     <= 1'b0;
      aw_done        <= 1'b0;
      b_pending      <= 1'b0;
    end else begin
      rng <= xorshift32(rng);
      // read address then data after a random wait
      if (mem_ar_valid_i && mem_ar_ready_o) begin
        mem_ar_ready_o <= 1'b0;
        rd_addr        <= mem_ar_addr_i;
        rd_wait        <= rng[2:0];
        rd_pending     <= 1'b1;
      end else if (mem_ar_valid_i && !rd_pending && !mem_r_valid_o) begin
        mem_ar_ready_o <= rng[3];
      end
      if (rd_pending) begin
        if (rd_wait == 0) begin
          mem_r_valid_o <= 1'b1;
          mem_r_data_o  <= peek(rd_addr);
          rd_pending    <= 1'b0;
        end else begin
          rd_wait <= rd_wait - 1;
        end
      end
      if (mem_r_valid_o && mem_r_ready_i) mem_r_valid_o <= 1'b0;
      // write address, data, then response
      if (mem_aw_valid_i && mem_aw_ready_o) begin
        mem_aw_ready_o <= 1'b0;
        wr_addr        <= mem_aw_addr_i;
        aw_done        <= 1'b1;
      end else if (mem_aw_valid_i && !aw_done && !b_pending && !mem_b_valid_o) begin
        mem_aw_ready_o <= rng[4];
      end
      if (mem_w_valid_i && mem_w_ready_o) begin
        if (!store.exists(wr_addr[31:3])) store[wr_addr[31:3]] = peek(wr_addr);
        for (int b = 0; b < 8; b++) begin
          if (mem_w_strb_i[b]) store[wr_addr[31:3]][b*8 +: 8] = mem_w_data_i[b*8 +: 8];
        end
        mem_w_ready_o <= 1'b0;
        aw_done       <= 1'b0;
        b_wait        <= rng[7:5];
        b_pending     <= 1'b1;
      end else if (mem_w_valid_i && aw_done) begin
        mem_w_ready_o <= rng[8];
      end
      if (b_pending) begin
        if (b_wait == 0) begin
          mem_b_valid_o <= 1'b1;
          b_pending     <= 1'b0;
        end else begin
          b_wait <= b_wait - 1;
        end
      end
      if (mem_b_valid_o && mem_b_ready_i) mem_b_valid_o <= 1'b0;
    end
  end

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ps
// dcache testbench
// cpu-side stimulus against a shadow byte model, random memory delays
module tb_dcache;

  localparam int timeout = 200;

  logic clk, rst;
  logic ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  logic aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic [31:0] ar_addr_i, aw_addr_i, mem_ar_addr_o, mem_aw_addr_o;
  logic [63:0] r_data_o, w_data_i, mem_r_data_i, mem_w_data_o;
  logic [7:0]  w_strb_i, mem_w_strb_o;
  logic [1:0]  r_resp_o, b_resp_o, mem_r_resp_i, mem_b_resp_i;
  logic mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  logic mem_b_valid_i, mem_b_ready_o;

  logic [7:0]  shadow [logic [31:0]];
  logic [31:0] rng = 32'haf13_72af;
  logic        stall_en = 1'b0;
  int          checks = 0;
  int          errors = 0;

  dcache_top #(.index_width(6)) dut_i (.*);

  tb_axi_mem mem_i (
    .clk(clk), .rst(rst),
    .mem_ar_valid_i(mem_ar_valid_o), .mem_ar_ready_o(mem_ar_ready_i),
    .mem_ar_addr_i(mem_ar_addr_o), .mem_r_valid_o(mem_r_valid_i),
    .mem_r_ready_i(mem_r_ready_o), .mem_r_data_o(mem_r_data_i), .mem_r_resp_o(mem_r_resp_i),
    .mem_aw_valid_i(mem_aw_valid_o), .mem_aw_ready_o(mem_aw_ready_i),
    .mem_aw_addr_i(mem_aw_addr_o), .mem_w_valid_i(mem_w_valid_o),
    .mem_w_ready_o(mem_w_ready_i), .mem_w_strb_i(mem_w_strb_o), .mem_w_data_i(mem_w_data_o),
    .mem_b_valid_o(mem_b_valid_i), .mem_b_ready_i(mem_b_ready_o), .mem_b_resp_o(mem_b_resp_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // expected word from the shadow bytes over the initial {word addr, ~word addr} fill
  function automatic logic [63:0] expect_word(input logic [31:0] addr);
    logic [31:0] wa;
    logic [63:0] w;
    wa = {3'b000, addr[31:3]};
    w  = {wa, ~wa};
    for (int b = 0; b < 8; b++) begin
      if (shadow.exists({addr[31:3], 3'(b)})) w[b*8 +: 8] = shadow[{addr[31:3], 3'(b)}];
    end
    return w;
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("checks %0d, errors %0d", checks, errors + 1);
    $display("TEST FAILED");
    $finish;
  endtask

  // cpu-side ready by channel, 0 ar, 1 aw, 2 w
  function automatic logic cpu_ready(input int ch);
    case (ch)
      0:       return ar_ready_o;
      1:       return aw_ready_o;
      default: return w_ready_o;
    endcase
  endfunction

  task automatic wait_ready(input string what, input int ch);
    int n;
    n = 0;
    while (!cpu_ready(ch) && n < timeout) begin
      @(negedge clk);
      n++;
    end
    if (!cpu_ready(ch)) abort_on_timeout(what);
    else @(negedge clk);   // transfer took place on the edge just passed
  endtask

  task automatic wait_resp(input string what, input logic is_rd);
    int   n;
    logic got;
    logic rdy;
    n   = 0;
    got = 1'b0;
    while (!got && n < timeout) begin
      rdy = stall_en ? next_rand() % 3 != 0 : 1'b1;   // random back-pressure
      if (is_rd) r_ready_i = rdy;
      else b_ready_i = rdy;
      if (rdy && (is_rd ? r_valid_o : b_valid_o)) got = 1'b1;
      else @(negedge clk);
      n++;
    end
    if (!got) abort_on_timeout(what);
  endtask

  task automatic cpu_read(input string name, input logic [31:0] addr);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    wait_ready("ar_ready_o", 0);
    ar_valid_i = 1'b0;
    wait_resp("r_valid_o", 1'b1);
    check_eq(name, expect_word(addr), r_data_o);
    check_eq({name, " rresp"}, dcache_pkg::resp_okay, r_resp_o);
    @(negedge clk);
    r_ready_i = 1'b0;
  endtask

  task automatic cpu_write(input logic [31:0] addr, input logic [7:0] strb,
                           input logic [63:0] data);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    wait_ready("aw_ready_o", 1);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b1;
    w_strb_i   = strb;
    w_data_i   = data;
    wait_ready("w_ready_o", 2);
    w_valid_i = 1'b0;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) shadow[{addr[31:3], 3'(b)}] = data[b*8 +: 8];
    end
    wait_resp("b_valid_o", 1'b0);
    check_eq("write bresp", dcache_pkg::resp_okay, b_resp_o);
    @(negedge clk);
    b_ready_i = 1'b0;
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] r;
    logic [31:0] ev [3];
    int          matched;
    {ar_valid_i, aw_valid_i, w_valid_i, r_ready_i, b_ready_i} = '0;
    ar_addr_i = '0;
    aw_addr_i = '0;
    w_strb_i  = '0;
    w_data_i  = '0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // state right after reset
    check_eq("reset ready", 2'b11, {ar_ready_o, aw_ready_o});
    check_eq("reset valids", 0, {r_valid_o, b_valid_o, w_ready_o, mem_ar_valid_o,
             mem_aw_valid_o, mem_w_valid_o, mem_r_ready_o, mem_b_ready_o});
    check_eq("reset state", dcache_pkg::idle, dut_i.ctrl_i.state_q);

    cpu_read("cold read", 32'h0000_0100);
    cpu_read("warm read", 32'h0000_0100);

    cpu_write(32'h0000_0100, 8'b1010_0101, 64'h1122_3344_5566_7788);   // write hit
    cpu_read("merge hit", 32'h0000_0100);
    cpu_write(32'h0000_0208, 8'b0000_1100, 64'hdead_beef_cafe_f00d);   // write allocate
    cpu_read("merge alloc", 32'h0000_0208);

    // three tags on one index
    ev[0] = 32'h0000_0040;
    ev[1] = 32'h0000_0240;
    ev[2] = 32'h0000_0440;
    cpu_write(ev[0], 8'hff, 64'h0123_4567_89ab_cdef);
    cpu_write(ev[1], 8'hf0, 64'hfedc_ba98_7654_3210);
    cpu_read("evict trigger", ev[2]);
    matched = 0;
    for (int i = 0; i < 2; i++) begin
      if (mem_i.peek(ev[i]) === expect_word(ev[i])) matched++;
    end
    checks++;
    assert (matched > 0) else begin
      errors++;
      $display("no dirty line was written back to memory on eviction");
    end
    cpu_read("evicted 0", ev[0]);
    cpu_read("evicted 1", ev[1]);

    // random mix with response stalls
    stall_en = 1'b1;
    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      a = 32'h0000_1000 + {r[1:0], 3'b000} + {r[3:2], 9'h000};
      if (r[4]) cpu_write(a, r[12:5], {next_rand(), next_rand()});
      else cpu_read("random read", a);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
